// File: all.f
+incdir+verilog
verilog/stream_pkg.sv
verilog/tcdm_if.sv
verilog/load_source.sv
verilog/store_sink.sv
verilog/tcdm_arbiter.sv
verilog/tcdm_streamer.sv
verif/tcdm_streamer_chk.sv
verif/tcdm_streamer_tb.sv

// File: Bender.yml
package:
  name: tcdm_streamer

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/stream_pkg.sv
      - verilog/tcdm_if.sv
      - verilog/load_source.sv
      - verilog/store_sink.sv
      - verilog/tcdm_arbiter.sv
      - verilog/tcdm_streamer.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tcdm_streamer_chk.sv
      - verif/tcdm_streamer_tb.sv

// File: verif/tcdm_streamer_tb.sv
// TCDM streamer testbench with memory model, stream stimulus and reference checking

`include "stream_consts.svh"

`default_nettype none

module tcdm_streamer_tb import stream_pkg::*; ();

  localparam int    TIMEOUT  = 3000;
  localparam data_t READ_KEY = 32'h5a3c96e1;

  logic    clk_i, reset_i, start_i;
  addr_t   x_base_i, w_base_i, z_base_i;
  stride_t x_stride_i, w_stride_i, z_stride_i;
  count_t  x_count_i, w_count_i, z_count_i;
  logic    x_valid_o, x_ready_i, w_valid_o, w_ready_i, z_valid_i, z_ready_o;
  data_t   x_data_o, w_data_o, z_data_i;
  logic    mem_req_o, mem_wen_o, mem_gnt_i, mem_rvalid_i;
  addr_t   mem_addr_o;
  data_t   mem_wdata_o, mem_rdata_i;
  logic [`STREAM_DATA_W/8-1:0] mem_be_o;
  logic    busy_o, done_o;

  logic [31:0] lfsr_q;
  int      cycle_cnt, checks, errors, test_num, done_cnt;
  int      x_seen, w_seen, z_sent, x_hold;
  bit      aborted, bp_on, z_take;
  addr_t   cfg_x_base, cfg_w_base, cfg_z_base;
  stride_t cfg_x_stride, cfg_w_stride, cfg_z_stride;
  count_t  cfg_x_count, cfg_w_count, cfg_z_count;
  data_t   z_words [$];
  data_t   rd_data [$];
  int      rd_due [$];
  addr_t   wr_addr [$];
  data_t   wr_data [$];
  logic [3:0] wr_be [$];

  tcdm_streamer dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per bit
  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_rand_bit());
    end
    return v;
  endfunction

  // Every memory word holds its address XOR a fixed key
  function automatic data_t ref_read(input addr_t a);
    return a ^ READ_KEY;
  endfunction

  function automatic addr_t word_addr(input addr_t base, input stride_t stride, input int idx);
    return base + addr_t'(stride * idx);
  endfunction

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Memory model and stream drivers sample at negedge and drive 1 after posedge
  always begin
    @(negedge clk_i);
    z_take = z_valid_i & z_ready_o;
    if (!reset_i && mem_req_o && mem_gnt_i) begin
      if (mem_wen_o) begin
        wr_addr.push_back(mem_addr_o);
        wr_data.push_back(mem_wdata_o);
        wr_be.push_back(mem_be_o);
      end else begin
        rd_data.push_back(ref_read(mem_addr_o));
        rd_due.push_back(cycle_cnt + 1 + rand_bits(2));
      end
    end
    @(posedge clk_i);
    cycle_cnt++;
    #1;
    if (reset_i) begin
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
    end else begin
      mem_gnt_i = next_rand_bit();
      mem_rvalid_i = (rd_due.size() > 0) && (rd_due[0] <= cycle_cnt);
      if (mem_rvalid_i) begin
        mem_rdata_i = rd_data.pop_front();
        void'(rd_due.pop_front());
      end
      if (x_hold > 0) begin
        x_ready_i = 1'b0;
        x_hold--;
      end else begin
        x_ready_i = bp_on ? next_rand_bit() : 1'b1;
      end
      w_ready_i = bp_on ? next_rand_bit() : 1'b1;
      if (z_take) begin
        z_sent++;
      end
      // Valid and data hold until taken
      if (!z_valid_i || z_take) begin
        z_valid_i = (z_sent < cfg_z_count) && (bp_on ? next_rand_bit() : 1'b1);
        z_data_i  = (z_sent < cfg_z_count) ? z_words[z_sent] : '0;
      end
    end
  end

  // Compares every stream word and the end of each run against the reference
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (x_valid_o && x_ready_i) begin
        compare_value(x_seen < cfg_x_count, 1, "x word within count");
        compare_value(x_data_o, ref_read(word_addr(cfg_x_base, cfg_x_stride, x_seen)), "x word");
        x_seen++;
      end
      if (w_valid_o && w_ready_i) begin
        compare_value(w_seen < cfg_w_count, 1, "w word within count");
        compare_value(w_data_o, ref_read(word_addr(cfg_w_base, cfg_w_stride, w_seen)), "w word");
        w_seen++;
      end
      if (done_o) begin
        done_cnt++;
        compare_value(busy_o, 0, "busy_o falls with done_o");
        compare_value(x_seen, cfg_x_count, "x words seen at done");
        compare_value(w_seen, cfg_w_count, "w words seen at done");
        compare_value(wr_addr.size(), cfg_z_count, "z writes seen at done");
      end
    end
  end

  task automatic idle_after_reset();
    int errs_before;
    errs_before = errors;
    @(negedge clk_i);
    compare_value(mem_req_o, 0, "mem_req_o idle");
    compare_value(x_valid_o, 0, "x_valid_o idle");
    compare_value(w_valid_o, 0, "w_valid_o idle");
    compare_value(z_ready_o, 0, "z_ready_o idle");
    compare_value(busy_o, 0, "busy_o idle");
    compare_value(done_o, 0, "done_o idle");
    test_num++;
    $display("test %0d idle after reset: %s", test_num,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic run_streams(input string name,
                             input addr_t xb, input stride_t xs, input count_t xc,
                             input addr_t wb, input stride_t ws, input count_t wc,
                             input addr_t zb, input stride_t zs, input count_t zc,
                             input bit bp, input int stall, input bit restart);
    int errs_before;
    int done_before;
    bit seen_done;
    errs_before = errors;
    done_before = done_cnt;
    seen_done = 1'b0;
    @(negedge clk_i);
    cfg_x_base = xb;
    cfg_x_stride = xs;
    cfg_x_count = xc;
    cfg_w_base = wb;
    cfg_w_stride = ws;
    cfg_w_count = wc;
    cfg_z_base = zb;
    cfg_z_stride = zs;
    cfg_z_count = zc;
    x_seen = 0;
    w_seen = 0;
    z_sent = 0;
    z_words.delete();
    wr_addr.delete();
    wr_data.delete();
    wr_be.delete();
    for (int n = 0; n < zc; n++) begin
      z_words.push_back(data_t'(32'hc3a50000 + (test_num << 12) + n));
    end
    bp_on = bp;
    x_hold = stall;
    @(posedge clk_i);
    #1;
    {x_base_i, x_stride_i, x_count_i} = {xb, xs, xc};
    {w_base_i, w_stride_i, w_count_i} = {wb, ws, wc};
    {z_base_i, z_stride_i, z_count_i} = {zb, zs, zc};
    start_i = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    @(negedge clk_i);
    compare_value(busy_o, 1, "busy_o after start");
    if (restart) begin
      // Second start with other settings once W has finished and X still runs
      for (int n = 0; n < TIMEOUT && w_seen < wc; n++) begin
        @(posedge clk_i);
      end
      if (w_seen < wc) begin
        errors++;
        aborted = 1'b1;
        $display("Timeout: w stream not finished within %0d cycles in %s", TIMEOUT, name);
      end
      #1;
      x_base_i = xb + 32'h400;
      w_count_i = wc + 3;
      z_stride_i = -zs;
      start_i = 1'b1;
      @(negedge clk_i);
      compare_value(busy_o, 1, "busy_o during restart");
      @(posedge clk_i);
      #1;
      start_i = 1'b0;
    end
    for (int n = 0; n < TIMEOUT && !seen_done; n++) begin
      @(negedge clk_i);
      seen_done = done_o;
    end
    if (!seen_done) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: done_o did not pulse within %0d cycles in %s", TIMEOUT, name);
    end
    repeat (3) @(negedge clk_i);
    compare_value(done_cnt - done_before, 1, "done_o pulses per run");
    compare_value(busy_o, 0, "busy_o after done");
    compare_value(wr_addr.size(), zc, "z write count");
    for (int n = 0; n < wr_addr.size() && n < zc; n++) begin
      compare_value(wr_addr[n], word_addr(zb, zs, n), "z write address");
      compare_value(wr_data[n], z_words[n], "z write data");
      compare_value(wr_be[n], 4'hf, "z write byte enables");
    end
    test_num++;
    $display("test %0d %s: %s", test_num, name, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    lfsr_q = 32'h7af44701;
    {cycle_cnt, checks, errors, test_num, done_cnt} = '0;
    {x_seen, w_seen, z_sent, x_hold} = '0;
    {aborted, bp_on, z_take} = '0;
    {cfg_x_count, cfg_w_count, cfg_z_count} = '0;
    reset_i = 1'b1;
    start_i = 1'b0;
    {x_base_i, x_stride_i, x_count_i, w_base_i, w_stride_i, w_count_i} = '0;
    {z_base_i, z_stride_i, z_count_i} = '0;
    {x_ready_i, w_ready_i, z_valid_i, z_data_i} = '0;
    {mem_gnt_i, mem_rvalid_i, mem_rdata_i} = '0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (4) @(posedge clk_i);
    idle_after_reset();
    if (!aborted) run_streams("x and w loads", 'h1000, 4, 12, 'h2000, 8, 9, 'h8000, 4, 0, 0, 0, 0);
    if (!aborted) run_streams("z store beside loads", 'h3000, 4, 16, 'h4000, 4, 16,
                              'h8000, 4, 20, 1, 0, 0);
    if (!aborted) run_streams("back-pressure with x stall", 'h100, 12, 24, 'h5000, 4, 20,
                              'h9000, 16, 10, 1, 60, 0);
    if (!aborted) run_streams("negative stride, count one, restart", 'h7000, -4, 10,
                              'h6000, 4, 1, 'ha000, -8, 1, 1, 0, 1);
    if (!aborted) run_streams("done on a later run", 'h1800, 8, 5, 'h2800, 4, 7,
                              'hb000, 4, 6, 1, 0, 0);
    errors = errors + dut_i.chk_i.fail_cnt;
    $display("checks %0d, errors %0d, tests %0d", checks, errors, test_num);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tcdm_streamer_chk.sv
// Streamer checker: request stability, credit bound and single-cycle done pulse

`include "stream_consts.svh"

`default_nettype none

module tcdm_streamer_chk import stream_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  input logic    req_i,
  input logic    gnt_i,
  input addr_t   addr_i,
  input logic    wen_i,
  input data_t   wdata_i,
  input logic    done_i,
  input credit_t x_credits_i,
  input credit_t w_credits_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  // A waiting request keeps its address, direction and data
  property req_held;
    @(posedge clk_i) disable iff (reset_i)
      (req_i && !gnt_i) |=> (req_i && $stable(addr_i) && $stable(wen_i) && $stable(wdata_i));
  endproperty

  req_held_a : assert property (req_held) else begin
    $error("memory request changed while waiting for grant");
    fail_cnt++;
  end

  x_credits_a : assert property (@(posedge clk_i) disable iff (reset_i)
    x_credits_i <= credit_t'(`LOAD_FIFO_DEPTH)) else begin
    $error("x channel credits above FIFO depth");
    fail_cnt++;
  end

  w_credits_a : assert property (@(posedge clk_i) disable iff (reset_i)
    w_credits_i <= credit_t'(`LOAD_FIFO_DEPTH)) else begin
    $error("w channel credits above FIFO depth");
    fail_cnt++;
  end

  done_pulse_a : assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |=> !done_i) else begin
    $error("done_o high for two cycles");
    fail_cnt++;
  end

endmodule

bind tcdm_streamer tcdm_streamer_chk chk_i (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_i       (mem_req_o),
  .gnt_i       (mem_gnt_i),
  .addr_i      (mem_addr_o),
  .wen_i       (mem_wen_o),
  .wdata_i     (mem_wdata_o),
  .done_i      (done_o),
  .x_credits_i (i_x_source.credits_q),
  .w_credits_i (i_w_source.credits_q)
);

`default_nettype wire

// File: verilog/tcdm_streamer.sv
// TCDM streamer top: X/W load channels and Z store channel sharing one memory port

`include "stream_consts.svh"

`default_nettype none

module tcdm_streamer import stream_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        start_i,
  input  addr_t                       x_base_i,
  input  stride_t                     x_stride_i,
  input  count_t                      x_count_i,
  input  addr_t                       w_base_i,
  input  stride_t                     w_stride_i,
  input  count_t                      w_count_i,
  input  addr_t                       z_base_i,
  input  stride_t                     z_stride_i,
  input  count_t                      z_count_i,
  output logic                        x_valid_o,
  output data_t                       x_data_o,
  input  logic                        x_ready_i,
  output logic                        w_valid_o,
  output data_t                       w_data_o,
  input  logic                        w_ready_i,
  input  logic                        z_valid_i,
  input  data_t                       z_data_i,
  output logic                        z_ready_o,
  output logic                        mem_req_o,
  output addr_t                       mem_addr_o,
  output logic                        mem_wen_o,
  output data_t                       mem_wdata_o,
  output logic [`STREAM_DATA_W/8-1:0] mem_be_o,
  input  logic                        mem_gnt_i,
  input  logic                        mem_rvalid_i,
  input  data_t                       mem_rdata_i,
  output logic                        busy_o,
  output logic                        done_o
);

  logic                          start_go;
  logic [`NUM_LOAD_CHANNELS-1:0] load_done;
  logic                          z_done;

  tcdm_if x_port ();
  tcdm_if w_port ();
  tcdm_if z_port ();

  // A start during a run is dropped here
  assign start_go = start_i & ~busy_o;

  load_source i_x_source (
    .clk_i (clk_i), .reset_i (reset_i), .start_i (start_go),
    .base_i (x_base_i), .stride_i (x_stride_i), .count_i (x_count_i),
    .port (x_port), .valid_o (x_valid_o), .data_o (x_data_o),
    .ready_i (x_ready_i), .done_o (load_done[0])
  );

  load_source i_w_source (
    .clk_i (clk_i), .reset_i (reset_i), .start_i (start_go),
    .base_i (w_base_i), .stride_i (w_stride_i), .count_i (w_count_i),
    .port (w_port), .valid_o (w_valid_o), .data_o (w_data_o),
    .ready_i (w_ready_i), .done_o (load_done[1])
  );

  store_sink i_z_sink (
    .clk_i (clk_i), .reset_i (reset_i), .start_i (start_go),
    .base_i (z_base_i), .stride_i (z_stride_i), .count_i (z_count_i),
    .z_valid_i (z_valid_i), .z_data_i (z_data_i), .z_ready_o (z_ready_o),
    .port (z_port), .done_o (z_done)
  );

  tcdm_arbiter i_arbiter (
    .clk_i (clk_i), .reset_i (reset_i),
    .x_port (x_port), .w_port (w_port), .z_port (z_port),
    .mem_req_o (mem_req_o), .mem_addr_o (mem_addr_o), .mem_wen_o (mem_wen_o),
    .mem_be_o (mem_be_o), .mem_wdata_o (mem_wdata_o), .mem_gnt_i (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i), .mem_rdata_i (mem_rdata_i)
  );

  // Run ends once every channel reports done, busy drops as done pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_go) begin
        busy_o <= 1'b1;
      end else if (busy_o && (&load_done) && z_done) begin
        busy_o <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcdm_arbiter.sv
// Load/store arbiter onto the single memory port, with in-order read response routing

`include "stream_consts.svh"

`default_nettype none

module tcdm_arbiter import stream_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  tcdm_if.target                      x_port,
  tcdm_if.target                      w_port,
  tcdm_if.target                      z_port,
  output logic                        mem_req_o,
  output addr_t                       mem_addr_o,
  output logic                        mem_wen_o,
  output logic [`STREAM_DATA_W/8-1:0] mem_be_o,
  output data_t                       mem_wdata_o,
  input  logic                        mem_gnt_i,
  input  logic                        mem_rvalid_i,
  input  data_t                       mem_rdata_i
);

  localparam chan_id_t    X_ID  = 1'b0;
  localparam chan_id_t    W_ID  = 1'b1;
  localparam int unsigned ORD_W = $clog2(`ORDER_DEPTH);

  logic           sel_x;
  logic           sel_w;
  logic           sel_z;
  logic           hold_q;
  logic [2:0]     held_q;
  chan_id_t       last_q;
  logic           granted;
  chan_id_t       order_q [`ORDER_DEPTH];
  logic [ORD_W-1:0] wr_ptr_q;
  logic [ORD_W-1:0] rd_ptr_q;
  chan_id_t       head_id;

  // Z first, then X and W alternating on the last winner
  always_comb begin
    sel_x = 1'b0;
    sel_w = 1'b0;
    sel_z = 1'b0;
    if (hold_q) begin
      // Keep a stalled request on the port until the memory takes it
      {sel_w, sel_x, sel_z} = held_q;
    end else if (z_port.req) begin
      sel_z = 1'b1;
    end else if (x_port.req && w_port.req) begin
      sel_w = (last_q == X_ID);
      sel_x = (last_q == W_ID);
    end else begin
      sel_x = x_port.req;
      sel_w = w_port.req;
    end
  end

  assign mem_req_o   = sel_x | sel_w | sel_z;
  assign mem_addr_o  = sel_z ? z_port.add  : (sel_w ? w_port.add  : x_port.add);
  assign mem_wen_o   = sel_z ? z_port.wen  : (sel_w ? w_port.wen  : x_port.wen);
  assign mem_be_o    = sel_z ? z_port.be   : (sel_w ? w_port.be   : x_port.be);
  assign mem_wdata_o = sel_z ? z_port.data : (sel_w ? w_port.data : x_port.data);

  assign granted    = mem_req_o & mem_gnt_i;
  assign x_port.gnt = granted & sel_x;
  assign w_port.gnt = granted & sel_w;
  assign z_port.gnt = granted & sel_z;

  // Responses come back in order, the queue head names their owner
  assign head_id        = order_q[rd_ptr_q];
  assign x_port.r_valid = mem_rvalid_i & (head_id == X_ID);
  assign w_port.r_valid = mem_rvalid_i & (head_id == W_ID);
  assign z_port.r_valid = 1'b0;
  assign x_port.r_data  = mem_rdata_i;
  assign w_port.r_data  = mem_rdata_i;
  assign z_port.r_data  = mem_rdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hold_q   <= 1'b0;
      held_q   <= '0;
      last_q   <= W_ID;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      hold_q <= mem_req_o & ~mem_gnt_i;
      held_q <= {sel_w, sel_x, sel_z};
      if (granted && !sel_z) begin
        last_q   <= sel_w ? W_ID : X_ID;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (mem_rvalid_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (granted && !sel_z) begin
      order_q[wr_ptr_q] <= sel_w ? W_ID : X_ID;
    end
  end

endmodule

`default_nettype wire

// File: verilog/store_sink.sv
// Store channel: turns the Z stream into full-word writes along a strided sequence

`default_nettype none

module store_sink import stream_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    start_i,
  input  addr_t   base_i,
  input  stride_t stride_i,
  input  count_t  count_i,
  input  logic    z_valid_i,
  input  data_t   z_data_i,
  output logic    z_ready_o,
  tcdm_if.initiator port,
  output logic    done_o
);

  chan_state_e state_q;
  addr_t       addr_q;
  stride_t     stride_q;
  count_t      left_q;
  data_t       data_q;
  logic        req_q;
  logic        accept;

  // One word in flight at a time, so memory stalls reach the stream
  assign z_ready_o = (state_q == RUN) && !req_q;
  assign accept    = z_valid_i & z_ready_o;

  assign port.req  = req_q;
  assign port.add  = addr_q;
  assign port.wen  = 1'b1;
  assign port.data = data_q;
  assign port.be   = '1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      left_q  <= '0;
      req_q   <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      if (state_q == IDLE && start_i) begin
        addr_q   <= base_i;
        stride_q <= stride_i;
        left_q   <= count_i;
        done_o   <= (count_i == '0);
        state_q  <= (count_i == '0) ? IDLE : RUN;
      end
      if (accept) begin
        data_q <= z_data_i;
        req_q  <= 1'b1;
        left_q <= left_q - 1'b1;
        // Last word taken, only its write remains
        if (left_q == count_t'(1)) begin
          state_q <= DRAIN;
        end
      end
      if (req_q && port.gnt) begin
        req_q  <= 1'b0;
        addr_q <= addr_q + addr_t'(stride_q);
        if (state_q == DRAIN) begin
          state_q <= IDLE;
          done_o  <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/load_source.sv
// Load channel: strided reads under credit control, response FIFO, output stream

`include "stream_consts.svh"

`default_nettype none

module load_source import stream_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = `LOAD_FIFO_DEPTH
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    start_i,
  input  addr_t   base_i,
  input  stride_t stride_i,
  input  count_t  count_i,
  tcdm_if.initiator port,
  output logic    valid_o,
  output data_t   data_o,
  input  logic    ready_i,
  output logic    done_o
);

  localparam int unsigned PTR_W  = $clog2(FIFO_DEPTH);
  localparam int unsigned FILL_W = $clog2(FIFO_DEPTH + 1);

  chan_state_e state_q;
  addr_t       addr_q;
  stride_t     stride_q;
  count_t      req_left_q;
  count_t      pop_left_q;
  credit_t     credits_q;
  logic        issue;
  logic        pop;

  data_t             fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [FILL_W-1:0] fill_q;

  // A read goes out only while a FIFO slot is reserved for its answer
  assign port.req  = (state_q == RUN) && (credits_q != '0);
  assign port.add  = addr_q;
  assign port.wen  = 1'b0;
  assign port.data = '0;
  assign port.be   = '1;

  assign issue = port.req & port.gnt;
  assign pop   = valid_o & ready_i;

  assign valid_o = (fill_q != '0);
  assign data_o  = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      req_left_q <= '0;
      pop_left_q <= '0;
      done_o     <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            addr_q     <= base_i;
            stride_q   <= stride_i;
            req_left_q <= count_i;
            pop_left_q <= count_i;
            // Empty transfer finishes at once
            done_o     <= (count_i == '0);
            state_q    <= (count_i == '0) ? IDLE : RUN;
          end
        end
        RUN: begin
          if (issue) begin
            addr_q     <= addr_q + addr_t'(stride_q);
            req_left_q <= req_left_q - 1'b1;
            if (req_left_q == count_t'(1)) begin
              state_q <= DRAIN;
            end
          end
        end
        DRAIN: begin
          // Wait for the last word to leave on the stream
          if (pop && pop_left_q == count_t'(1)) begin
            state_q <= IDLE;
            done_o  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (pop) begin
        pop_left_q <= pop_left_q - 1'b1;
      end
    end
  end

  // One credit spent per granted read, one returned per pop
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q <= credit_t'(FIFO_DEPTH);
    end else begin
      credits_q <= credits_q + credit_t'(pop) - credit_t'(issue);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (port.r_valid) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + FILL_W'(port.r_valid) - FILL_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (port.r_valid) begin
      fifo_mem[wr_ptr_q] <= port.r_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcdm_if.sv
// TCDM port interface: one request/response port between a channel and the arbiter

`include "stream_consts.svh"

`default_nettype none

interface tcdm_if import stream_pkg::*; ();

  // Request side, held stable until granted
  logic                       req;
  logic                       gnt;
  addr_t                      add;
  logic                       wen;
  data_t                      data;
  logic [`STREAM_DATA_W/8-1:0] be;

  // Response side, one pulse per read in request order
  logic                       r_valid;
  data_t                      r_data;

  modport initiator (
    output req, add, wen, data, be,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, add, wen, data, be,
    output gnt, r_valid, r_data
  );

endinterface

`default_nettype wire

// File: verilog/stream_pkg.sv
// Stream package: vector types and FSM state encoding of the TCDM streamer

`include "stream_consts.svh"

`default_nettype none

package stream_pkg;

  typedef logic [`STREAM_ADDR_W-1:0] addr_t;
  typedef logic [`STREAM_DATA_W-1:0] data_t;
  typedef logic [`STREAM_COUNT_W-1:0] count_t;

  // Signed byte step between successive words
  typedef logic signed [`STREAM_ADDR_W-1:0] stride_t;

  // Index of a load channel, 0 is X and 1 is W
  typedef logic [0:0] chan_id_t;

  typedef logic [$clog2(`LOAD_FIFO_DEPTH+1)-1:0] credit_t;

  // Shared by the load and the store channel FSMs
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } chan_state_e;

endpackage

`default_nettype wire

// File: verilog/stream_consts.svh
// Stream constants for the TCDM streamer: widths, depths and channel count

`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Byte address width of the memory port
`define STREAM_ADDR_W 32

// Memory and stream word width
`define STREAM_DATA_W 32

// Width of a word count
`define STREAM_COUNT_W 16

// Response FIFO entries per load channel, also the initial credit count
`define LOAD_FIFO_DEPTH 4

// Load channels sharing the memory port behind the store channel
`define NUM_LOAD_CHANNELS 2

// Read order queue, sized for every credit of every load channel
`define ORDER_DEPTH 8

`endif
